// File: dv/bf_assert.sv
`timescale 1ns/100ps

module bf_assert (
   input logic                       clk,
   input logic                       rst,
   input logic                       rd_req,
   input logic                       wr_req,
   input logic                       data_empty,
   input logic                       req_empty,
   input logic                       req_pop,
   input bf_ctrl_pkg::engine_state_e state
);
   import bf_ctrl_pkg::*;

   // one strobe per cycle on the single port
   a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
      else $error("rd_req and wr_req high together");

   // every returned word used up before a request read goes out
   a_req_rd_drained: assert property (@(posedge clk) disable iff (rst)
      state == REQ_RD |-> data_empty)
      else $error("returned word left over at request read");

   a_req_pop_queued: assert property (@(posedge clk) disable iff (rst)
      req_pop |-> (state == REQ_WR && !req_empty))
      else $error("req_pop outside REQ_WR or with the request queue empty");

   a_reset_quiet: assert property (@(posedge clk) rst |=> (!rd_req && !wr_req))
      else $error("strobe high after reset edge");

endmodule

bind bf_engine bf_assert u_assert (
   .clk        (clk),
   .rst        (rst),
   .rd_req     (sram.rd_req),
   .wr_req     (sram.wr_req),
   .data_empty (data_empty),
   .req_empty  (req_empty),
   .req_pop    (req_pop),
   .state      (state)
);

// File: dv/bf_tb.sv
`timescale 1ns/100ps

module bf_tb;
   import bf_word_pkg::*;
   import bf_ctrl_pkg::*;

   localparam int DEPTH  = 16;
   localparam int EPOCHS = 300;   // clocks per epoch
   localparam int BATCH  = 6;

   logic       clk;
   logic       rst;
   logic       req_valid;
   req_kind_t  req_kind;
   sram_addr_t req_hash0;
   sram_addr_t req_hash1;
   logic       req_ready;
   logic       sram_rd_req;
   sram_addr_t sram_rd_addr;
   sram_word_t sram_rd_data;
   logic       sram_rd_vld;
   logic       sram_wr_req;
   sram_addr_t sram_wr_addr;
   sram_word_t sram_wr_data;

   integer     seed = 32'h7a54ebea;
   int         errors = 0;
   int         tests = 0;
   int         failed_tests = 0;
   int         cyc = 0;        // edges since reset release
   int         tick = 0;
   int         rst_edges = 0;
   int         n_writes = 0;
   int         n_op_writes = 0;

   sram_word_t sram_mem [DEPTH];
   sram_word_t model [DEPTH];    // last written word per address
   sram_word_t rd_data_q [$];
   int         rd_due_q [$];
   sram_addr_t rd_addr_q [$];    // read addresses awaiting their write-back
   int         last_due = 0;
   int         rd_delay;
   int         due;

   sram_addr_t op_addr [$];      // expected request writes, in order
   req_kind_t  op_kind [$];
   int         batch_cnt = 0;
   int         op_cnt = 0;
   int         scrub_ptr = 0;

   bf_top #(.TABLE_DEPTH(DEPTH), .EPOCH_CYCLES(EPOCHS), .SCRUB_BATCH(BATCH)) UUT (
      .clk          (clk),
      .rst          (rst),
      .req_valid    (req_valid),
      .req_kind     (req_kind),
      .req_hash0    (req_hash0),
      .req_hash1    (req_hash1),
      .req_ready    (req_ready),
      .sram_rd_req  (sram_rd_req),
      .sram_rd_addr (sram_rd_addr),
      .sram_rd_data (sram_rd_data),
      .sram_rd_vld  (sram_rd_vld),
      .sram_wr_req  (sram_wr_req),
      .sram_wr_addr (sram_wr_addr),
      .sram_wr_data (sram_wr_data)
   );

   always #20 clk = !clk;

   // aging, then insert or remove, straight from the bucket rules
   function automatic sram_word_t ref_word(input sram_word_t old, input epoch_t ep,
                                           input sram_addr_t addr, input bit do_op,
                                           input req_kind_t kind);
      bucket_t b [NUM_BUCKETS];
      epoch_t  age;
      int      src;
      bit      done;
      sram_word_t w;
      age  = ep - old[EPOCH_LSB +: EPOCH_BITS];
      done = 0;
      for (int i = 0; i < NUM_BUCKETS; i++) begin
         src = i + int'(age);
         if (src < NUM_BUCKETS)
            b[i] = old[BUCKET_LSB + src*BUCKET_BITS +: BUCKET_BITS];
         else
            b[i] = '0;
      end
      if (do_op && kind == 1'b1) begin
         if (b[NUM_BUCKETS-1] != 4'd15)
            b[NUM_BUCKETS-1] = b[NUM_BUCKETS-1] + 4'd1;
      end else if (do_op) begin
         for (int i = NUM_BUCKETS - 1; i >= 0; i--) begin
            if (!done && b[i] != 0) begin
               b[i] = b[i] - 4'd1;
               done = 1;
            end
         end
      end
      w = '0;
      for (int i = 0; i < NUM_BUCKETS; i++)
         w[BUCKET_LSB + i*BUCKET_BITS +: BUCKET_BITS] = b[i];
      w[EPOCH_LSB +: EPOCH_BITS] = ep;
      w[TAG_BITS-1:0] = addr[TAG_BITS-1:0];
      return w;
   endfunction

   task automatic check_word(input sram_word_t got, input sram_word_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s word %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input sram_addr_t got, input sram_addr_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s address %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_epoch(input epoch_t got, input epoch_t exp, input string what);
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t: %s epoch %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic abort_run(input string what);
      $display("timeout while waiting for %s", what);
      $display("Test failed");
      $finish;
   endtask

   always @(posedge clk) begin
      if (rst) begin
         cyc <= 0;
         rst_edges <= rst_edges + 1;
      end else begin
         cyc <= cyc + 1;
      end
      if (req_valid && req_ready) begin
         op_addr.push_back(req_hash0);
         op_kind.push_back(req_kind);
         op_addr.push_back(req_hash1);
         op_kind.push_back(req_kind);
      end
   end

   // SRAM model with in-order read latency of 2 to 4 cycles
   always @(posedge clk) begin
      tick++;
      if (sram_wr_req)
         sram_mem[sram_wr_addr[3:0]] = sram_wr_data;
      if (sram_rd_req) begin
         rd_delay = 2 + int'($unsigned($random(seed)) % 3);
         due = tick + rd_delay;
         if (due < last_due)
            due = last_due;
         last_due = due;
         rd_data_q.push_back(sram_mem[sram_rd_addr[3:0]]);
         rd_due_q.push_back(due);
         rd_addr_q.push_back(sram_rd_addr);
      end
      #2;
      if (rd_due_q.size() > 0 && rd_due_q[0] <= tick) begin
         sram_rd_vld  = 1'b1;
         sram_rd_data = rd_data_q.pop_front();
         void'(rd_due_q.pop_front());
      end else begin
         sram_rd_vld = 1'b0;
      end
   end

   // compare every write against the model, sampled mid-cycle
   always @(negedge clk) begin
      sram_word_t aged;
      sram_word_t upd;
      epoch_t     ep;
      bit         is_op;
      if (rst && rst_edges > 0 && (sram_rd_req || sram_wr_req)) begin
         errors++;
         $display("ERROR at %0t: strobe high during reset", $time);
      end
      if (!rst && sram_wr_req) begin
         n_writes++;
         // each word goes back where it was read from
         if (rd_addr_q.size() == 0) begin
            errors++;
            $display("write to address %0d with no read before it", sram_wr_addr);
         end else begin
            check_addr(sram_wr_addr, rd_addr_q.pop_front(), "write-back");
         end
         ep = epoch_t'((cyc - 1) / EPOCHS);
         check_epoch(sram_wr_data[EPOCH_LSB +: EPOCH_BITS], ep, "write stamp");
         aged  = ref_word(model[sram_wr_addr[3:0]], ep, sram_wr_addr, 0, 1'b0);
         is_op = 0;
         upd   = aged;
         if (batch_cnt == BATCH && op_addr.size() > 0 && sram_wr_addr == op_addr[0]) begin
            upd = ref_word(model[sram_wr_addr[3:0]], ep, sram_wr_addr, 1, op_kind[0]);
            is_op = (sram_wr_data == upd);
         end
         if (is_op) begin
            void'(op_addr.pop_front());
            void'(op_kind.pop_front());
            n_op_writes++;
            op_cnt++;
            if (op_cnt == 2) begin
               op_cnt    = 0;
               batch_cnt = 0;
            end
            model[sram_wr_addr[3:0]] = upd;
         end else begin
            if (batch_cnt == BATCH) begin
               batch_cnt = 0;
               op_cnt    = 0;
            end
            check_addr(sram_wr_addr, sram_addr_t'(scrub_ptr), "scrub write");
            check_word(sram_wr_data, aged, "scrub write");
            scrub_ptr = (scrub_ptr + 1) % DEPTH;
            batch_cnt++;
            model[sram_wr_addr[3:0]] = sram_wr_data;
         end
      end
   end

   task automatic wait_cycles(input int n);
      for (int i = 0; i < n; i++)
         @(posedge clk);
   endtask

   task automatic wait_ops_drained(input int limit);
      int t;
      t = 0;
      while (op_addr.size() > 0) begin
         @(posedge clk);
         t++;
         if (t > limit)
            abort_run("request writes to drain");
      end
   endtask

   task automatic send_req(input req_kind_t kind, input sram_addr_t h0, input sram_addr_t h1);
      int t;
      t = 0;
      @(posedge clk);
      #2;
      while (!req_ready) begin
         @(posedge clk);
         #2;
         t++;
         if (t > 2000)
            abort_run("req_ready");
      end
      req_valid = 1'b1;
      req_kind  = kind;
      req_hash0 = h0;
      req_hash1 = h1;
      @(posedge clk);
      #2;
      req_valid = 1'b0;
   endtask

   task automatic end_test(input string name, input int err_before);
      tests++;
      if (errors != err_before) begin
         failed_tests++;
         $display("%s: FAIL (%0d errors)", name, errors - err_before);
      end else begin
         $display("%s: ok", name);
      end
   endtask

   function automatic sram_addr_t rand_hash();
      return sram_addr_t'($unsigned($random(seed)) % DEPTH);
   endfunction

   initial begin
      int e;
      int t;
      bit saw_full;
      clk          = 1'b0;
      rst          = 1'b1;
      req_valid    = 1'b0;
      req_kind     = 1'b0;
      req_hash0    = '0;
      req_hash1    = '0;
      sram_rd_data = '0;
      sram_rd_vld  = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         sram_mem[i] = {{VEC_BITS{1'b0}}, 8'd0, tag_t'(i)};
         model[i]    = sram_mem[i];
      end

      // 1: reset and first writes
      e = errors;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      @(posedge clk);
      #2;
      if (!req_ready) begin
         errors++;
         $display("ERROR at %0t: req_ready low after reset release", $time);
      end
      t = 0;
      while (n_writes == 0) begin
         @(posedge clk);
         t++;
         if (t > 200)
            abort_run("first scrub write");
      end
      end_test("reset", e);

      // 2: scrub aging over several epochs
      e = errors;
      wait_cycles(EPOCHS * 3 + 50);
      end_test("scrub aging", e);

      // 3: inserts, enough to saturate bucket 11
      e = errors;
      for (int i = 0; i < 9; i++)
         send_req(1'b1, 19'd5, 19'd5);
      send_req(1'b1, 19'd2, 19'd9);
      wait_ops_drained(5000);
      end_test("insert", e);

      // 4: removes on loaded and on empty words
      e = errors;
      send_req(1'b0, 19'd5, 19'd9);
      send_req(1'b0, 19'd12, 19'd12);
      for (int i = 0; i < 4; i++)
         send_req(1'b0, rand_hash(), rand_hash());
      wait_ops_drained(5000);
      end_test("remove", e);

      // 5: counts decay to zero after 12 epochs
      e = errors;
      for (int i = 0; i < 3; i++)
         send_req(1'b1, 19'd7, 19'd7);
      wait_ops_drained(5000);
      wait_cycles(EPOCHS * 13 + 100);
      check_word(model[7], {{VEC_BITS{1'b0}}, model[7][EPOCH_LSB +: EPOCH_BITS], tag_t'(7)},
                 "decayed word");
      end_test("decay", e);

      // 6: burst until the request queue pushes back
      e = errors;
      saw_full = 0;
      for (int i = 0; i < 40; i++) begin
         @(posedge clk);
         #2;
         if (req_ready) begin
            req_valid = 1'b1;
            req_kind  = req_kind_t'($random(seed));
            req_hash0 = rand_hash();
            req_hash1 = rand_hash();
         end else begin
            req_valid = 1'b0;
            saw_full  = 1;
         end
      end
      @(posedge clk);
      #2;
      req_valid = 1'b0;
      if (!saw_full) begin
         errors++;
         $display("req_ready never went low during the burst");
      end
      wait_ops_drained(20000);
      end_test("back-pressure", e);

      $display("tests %0d, failed %0d, errors %0d, request writes %0d, writes %0d",
               tests, failed_tests, errors, n_op_writes, n_writes);
      if (errors == 0 && failed_tests == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: project.f
source/bf_word_pkg.sv
source/bf_ctrl_pkg.sv
source/bf_sram_if.sv
source/epoch_timer.sv
source/small_fifo.sv
source/bucket_update.sv
source/bf_engine.sv
source/bf_top.sv
dv/bf_assert.sv
dv/bf_tb.sv

// File: run.sh
#!/bin/sh
# build and run the Bloom filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f project.f --top-module bf_tb -o bf_sim

out=$(./obj_dir/bf_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
   exit 0
fi
exit 1

// File: source/bf_ctrl_pkg.sv
package bf_ctrl_pkg;

   // request kind, insert or remove
   typedef logic req_kind_t;

   localparam req_kind_t KIND_INSERT = 1'b1;

   // scrub batch then at most one request
   typedef enum logic [1:0] {
      SCRUB_RD,
      SCRUB_WR,
      REQ_RD,
      REQ_WR
   } engine_state_e;

endpackage

// File: source/bf_engine.sv
`timescale 1ns/100ps

module bf_engine #(
   parameter int TABLE_DEPTH = 1024,
   parameter int SCRUB_BATCH = 6
) (
   input  logic                    clk,
   input  logic                    rst,
   input  bf_word_pkg::epoch_t     epoch,
   bf_sram_if.engine               sram,
   input  logic                    req_empty,
   output logic                    req_pop,
   input  bf_ctrl_pkg::req_kind_t  req_kind,
   input  bf_word_pkg::sram_addr_t req_hash0,
   input  bf_word_pkg::sram_addr_t req_hash1,
   input  logic                    data_empty,
   output logic                    data_pop,
   input  bf_word_pkg::sram_word_t data_word
);
   import bf_word_pkg::*;
   import bf_ctrl_pkg::*;

   localparam int CNT_BITS = $clog2(SCRUB_BATCH + 1);
   localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(SCRUB_BATCH - 1);

   engine_state_e       state;
   sram_addr_t          rd_ptr;     // scrub read pointer
   sram_addr_t          wr_ptr;     // scrub write pointer, trails rd_ptr
   logic [CNT_BITS-1:0] rd_cnt;
   logic [CNT_BITS-1:0] wr_cnt;
   logic                hash_sel;   // 0 for hash0, 1 for hash1
   sram_addr_t          req_addr;
   sram_addr_t          upd_addr;
   sram_word_t          upd_word;
   logic                do_op;
   logic                wr_take;

   function automatic sram_addr_t wrap_inc(input sram_addr_t p);
      if (p == sram_addr_t'(TABLE_DEPTH - 1))
         return '0;
      return p + 1'b1;
   endfunction

   assign req_addr = hash_sel ? req_hash1 : req_hash0;
   assign do_op    = (state == REQ_WR);
   assign upd_addr = do_op ? req_addr : wr_ptr;

   // a returned word is popped and written back in the same step
   assign wr_take  = (state == SCRUB_WR || state == REQ_WR) && !data_empty;
   assign data_pop = wr_take;
   assign req_pop  = do_op && !data_empty && hash_sel;   // after the hash1 write

   bucket_update u_update (
      .word_in  (data_word),
      .epoch    (epoch),
      .addr     (upd_addr),
      .do_op    (do_op),
      .kind     (req_kind),
      .word_out (upd_word)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= SCRUB_RD;
         rd_ptr      <= '0;
         wr_ptr      <= '0;
         rd_cnt      <= '0;
         wr_cnt      <= '0;
         hash_sel    <= 1'b0;
         sram.rd_req <= 1'b0;
         sram.wr_req <= 1'b0;
      end else begin
         sram.rd_req <= 1'b0;
         sram.wr_req <= wr_take;
         case (state)
            SCRUB_RD: begin
               sram.rd_req <= 1'b1;
               rd_ptr      <= wrap_inc(rd_ptr);
               if (rd_cnt == LAST) begin
                  rd_cnt <= '0;
                  state  <= SCRUB_WR;
               end else begin
                  rd_cnt <= rd_cnt + 1'b1;
               end
            end
            SCRUB_WR: begin
               if (wr_take) begin
                  wr_ptr <= wrap_inc(wr_ptr);
                  if (wr_cnt == LAST) begin
                     wr_cnt <= '0;
                     state  <= req_empty ? SCRUB_RD : REQ_RD;
                  end else begin
                     wr_cnt <= wr_cnt + 1'b1;
                  end
               end
            end
            REQ_RD: begin
               sram.rd_req <= 1'b1;
               state       <= REQ_WR;
            end
            REQ_WR: begin
               if (wr_take) begin
                  hash_sel <= !hash_sel;
                  state    <= hash_sel ? SCRUB_RD : REQ_RD;
               end
            end
            default: state <= SCRUB_RD;
         endcase
      end
   end

   // addresses and data only matter alongside their strobe
   always_ff @(posedge clk) begin
      if (state == SCRUB_RD)
         sram.rd_addr <= rd_ptr;
      else if (state == REQ_RD)
         sram.rd_addr <= req_addr;
      if (wr_take) begin
         sram.wr_addr <= upd_addr;
         sram.wr_data <= upd_word;   // stamped with the epoch of this cycle
      end
   end

endmodule

// File: source/bf_sram_if.sv
`timescale 1ns/100ps

interface bf_sram_if;
   import bf_word_pkg::*;

   logic       rd_req;    // one-cycle strobe
   sram_addr_t rd_addr;
   logic       wr_req;    // one-cycle strobe
   sram_addr_t wr_addr;
   sram_word_t wr_data;
   sram_word_t rd_data;
   logic       rd_vld;    // returns in request order

   modport engine (
      output rd_req, rd_addr, wr_req, wr_addr, wr_data
   );

   // memory side, no ack on either strobe
   modport mem (
      input  rd_req, rd_addr, wr_req, wr_addr, wr_data,
      output rd_data, rd_vld
   );

endinterface

// File: source/bf_top.sv
`timescale 1ns/100ps

module bf_top #(
   parameter int TABLE_DEPTH  = 1024,
   parameter int EPOCH_CYCLES = 2032,
   parameter int SCRUB_BATCH  = 6
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    req_valid,
   input  bf_ctrl_pkg::req_kind_t  req_kind,
   input  bf_word_pkg::sram_addr_t req_hash0,
   input  bf_word_pkg::sram_addr_t req_hash1,
   output logic                    req_ready,
   output logic                    sram_rd_req,
   output bf_word_pkg::sram_addr_t sram_rd_addr,
   input  bf_word_pkg::sram_word_t sram_rd_data,
   input  logic                    sram_rd_vld,
   output logic                    sram_wr_req,
   output bf_word_pkg::sram_addr_t sram_wr_addr,
   output bf_word_pkg::sram_word_t sram_wr_data
);
   import bf_word_pkg::*;
   import bf_ctrl_pkg::*;

   localparam int REQ_BITS = 1 + 2 * ADDR_BITS;

   epoch_t              epoch;
   logic                req_full_n;   // not nearly full
   logic                req_nf;
   logic                req_empty;
   logic                req_pop;
   logic [REQ_BITS-1:0] req_dout;
   req_kind_t           q_kind;
   sram_addr_t          q_hash0;
   sram_addr_t          q_hash1;
   logic                data_empty;
   logic                data_pop;
   sram_word_t          data_word;

   bf_sram_if sram ();

   assign sram.rd_data = sram_rd_data;
   assign sram.rd_vld  = sram_rd_vld;
   assign sram_rd_req  = sram.rd_req;
   assign sram_rd_addr = sram.rd_addr;
   assign sram_wr_req  = sram.wr_req;
   assign sram_wr_addr = sram.wr_addr;
   assign sram_wr_data = sram.wr_data;

   // offers while not ready are dropped
   assign req_full_n = !req_nf;
   assign req_ready  = req_full_n;
   assign {q_kind, q_hash1, q_hash0} = req_dout;

   epoch_timer #(.EPOCH_CYCLES(EPOCH_CYCLES)) u_timer (
      .clk   (clk),
      .rst   (rst),
      .epoch (epoch)
   );

   small_fifo #(.WIDTH(REQ_BITS), .DEPTH_BITS(3)) req_queue (
      .clk         (clk),
      .rst         (rst),
      .din         ({req_kind, req_hash1, req_hash0}),
      .wr_en       (req_valid && req_full_n),
      .rd_en       (req_pop),
      .dout        (req_dout),
      .empty       (req_empty),
      .nearly_full (req_nf)
   );

   // 8 entries hold a whole scrub batch
   small_fifo #(.WIDTH(WORD_BITS), .DEPTH_BITS(3)) rd_queue (
      .clk         (clk),
      .rst         (rst),
      .din         (sram.rd_data),
      .wr_en       (sram.rd_vld),
      .rd_en       (data_pop),
      .dout        (data_word),
      .empty       (data_empty),
      .nearly_full ()
   );

   bf_engine #(.TABLE_DEPTH(TABLE_DEPTH), .SCRUB_BATCH(SCRUB_BATCH)) u_engine (
      .clk        (clk),
      .rst        (rst),
      .epoch      (epoch),
      .sram       (sram.engine),
      .req_empty  (req_empty),
      .req_pop    (req_pop),
      .req_kind   (q_kind),
      .req_hash0  (q_hash0),
      .req_hash1  (q_hash1),
      .data_empty (data_empty),
      .data_pop   (data_pop),
      .data_word  (data_word)
   );

endmodule

// File: source/bf_word_pkg.sv
package bf_word_pkg;

   localparam int BUCKET_BITS = 4;
   localparam int NUM_BUCKETS = 12;
   localparam int EPOCH_BITS  = 8;
   localparam int TAG_BITS    = 16;
   localparam int ADDR_BITS   = 19;

   // word layout from msb down: buckets, epoch stamp, tag
   localparam int VEC_BITS   = NUM_BUCKETS * BUCKET_BITS;
   localparam int WORD_BITS  = VEC_BITS + EPOCH_BITS + TAG_BITS;  // 72
   localparam int EPOCH_LSB  = TAG_BITS;
   localparam int BUCKET_LSB = TAG_BITS + EPOCH_BITS;

   typedef logic [BUCKET_BITS-1:0] bucket_t;
   typedef logic [VEC_BITS-1:0]    bucket_vec_t;   // bucket 11 in the top nibble
   typedef logic [EPOCH_BITS-1:0]  epoch_t;
   typedef logic [TAG_BITS-1:0]    tag_t;
   typedef logic [ADDR_BITS-1:0]   sram_addr_t;
   typedef logic [WORD_BITS-1:0]   sram_word_t;

endpackage

// File: source/bucket_update.sv
`timescale 1ns/100ps

module bucket_update (
   input  bf_word_pkg::sram_word_t word_in,
   input  bf_word_pkg::epoch_t     epoch,
   input  bf_word_pkg::sram_addr_t addr,
   input  logic                    do_op,
   input  bf_ctrl_pkg::req_kind_t  kind,
   output bf_word_pkg::sram_word_t word_out
);
   import bf_word_pkg::*;
   import bf_ctrl_pkg::*;

   localparam int TOP_LSB = (NUM_BUCKETS - 1) * BUCKET_BITS;

   epoch_t      age;
   bucket_vec_t aged;
   bucket_vec_t result;
   bucket_t     top_b;
   tag_t        tag;

   assign age = epoch - word_in[EPOCH_LSB +: EPOCH_BITS];  // modulo 256

   // each epoch moves every count one bucket down
   assign aged  = (age >= EPOCH_BITS'(NUM_BUCKETS)) ? '0 :
                  word_in[BUCKET_LSB +: VEC_BITS] >> (age * BUCKET_BITS);
   assign top_b = aged[TOP_LSB +: BUCKET_BITS];
   assign tag   = addr[TAG_BITS-1:0];

   always_comb begin
      logic found;
      found  = 1'b0;
      result = aged;
      if (do_op) begin
         if (kind == KIND_INSERT) begin
            if (top_b != '1)
               result[TOP_LSB +: BUCKET_BITS] = top_b + 1'b1;   // saturate at 15
         end else begin
            // highest nonzero bucket gives up one
            for (int i = NUM_BUCKETS - 1; i >= 0; i--) begin
               if (!found && aged[i*BUCKET_BITS +: BUCKET_BITS] != '0) begin
                  result[i*BUCKET_BITS +: BUCKET_BITS] = aged[i*BUCKET_BITS +: BUCKET_BITS] - 1'b1;
                  found = 1'b1;
               end
            end
         end
      end
   end

   assign word_out = {result, epoch, tag};

endmodule

// File: source/epoch_timer.sv
`timescale 1ns/100ps

module epoch_timer #(
   parameter int EPOCH_CYCLES = 2032
) (
   input  logic               clk,
   input  logic               rst,
   output bf_word_pkg::epoch_t epoch
);

   localparam int CNT_BITS = $clog2(EPOCH_CYCLES + 1);

   logic [CNT_BITS-1:0] cnt;

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt   <= '0;
         epoch <= '0;
      end else if (cnt == CNT_BITS'(EPOCH_CYCLES - 1)) begin
         cnt   <= '0;
         epoch <= epoch + 1'b1;    // wraps at 256
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

// File: source/small_fifo.sv
`timescale 1ns/100ps

module small_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_BITS = 3
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] din,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [WIDTH-1:0] dout,
   output logic             empty,
   output logic             nearly_full
);

   localparam int DEPTH = 1 << DEPTH_BITS;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   assign do_rd = rd_en && !empty;
   assign do_wr = wr_en && (count != (DEPTH_BITS+1)'(DEPTH));  // full drops the write

   assign dout        = mem[rd_ptr];   // head shows through
   assign empty       = (count == '0);
   assign nearly_full = (count >= (DEPTH_BITS+1)'(DEPTH - 1));

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule
